//--- source/rapid_pkg.sv
package rapid_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths with a meaning
    ////////////////////////////////////////////////////////////////////////////

    // Data, pc and instruction words
    typedef logic [31:0] word_t;
    // Register index
    typedef logic [4:0]  reg_addr_t;
    // Operation select inside a block
    typedef logic [2:0]  funct3_t;

    ////////////////////////////////////////////////////////////////////////////
    // Encodings
    ////////////////////////////////////////////////////////////////////////////

    // Major opcode families, bits 6:0
    typedef enum logic [6:0] {
        OP_UPPER    = 7'b0110111,
        OP_UPPER_PC = 7'b0010111,
        OP_JAL      = 7'b1101111,
        OP_JALR     = 7'b1100111,
        OP_BRANCH   = 7'b1100011,
        OP_LOAD     = 7'b0000011,
        OP_STORE    = 7'b0100011,
        OP_ALU_IMM  = 7'b0010011,
        OP_ALU_REG  = 7'b0110011
    } opcode_e;

    // ALU ops by funct3
    typedef enum logic [2:0] {
        ALU_ADD  = 3'b000,
        ALU_SLL  = 3'b001,
        ALU_SLT  = 3'b010,
        ALU_SLTU = 3'b011,
        ALU_XOR  = 3'b100,
        ALU_SRL  = 3'b101,
        ALU_OR   = 3'b110,
        ALU_AND  = 3'b111
    } alu_op_e;

    // Branch compares by funct3
    typedef enum logic [2:0] {
        BR_EQ  = 3'b000,
        BR_NE  = 3'b001,
        BR_LT  = 3'b100,
        BR_GE  = 3'b101,
        BR_LTU = 3'b110,
        BR_GEU = 3'b111
    } branch_op_e;

    // Decoded control bundle
    // One block flag per family, fcs_opcode picks the op inside it
    typedef struct packed {
        logic    load_upper;
        logic    upper_pc;
        logic    jump;
        logic    jump_reg;
        logic    cond_branch;
        logic    alu_imm;
        logic    alu_reg;
        logic    illegal;
        logic    iop;
        logic    uses_rd;
        funct3_t fcs_opcode;
    } control_s;

    // Core sequencing
    typedef enum logic [1:0] {
        WAIT,
        DECODE,
        EXECUTE,
        WRITEBACK
    } core_state_e;

endpackage

//--- source/decode_if.sv
interface decode_if;
    import rapid_pkg::*;

    // Control flags and operation select
    control_s  control;

    // Register fields
    reg_addr_t rs1;
    reg_addr_t rs2;
    // Zero when the family writes nothing
    reg_addr_t rd;

    // Sign-extended immediate
    word_t     imm;
    // Pc of the instruction in flight
    word_t     pc;

    // Decoder drives everything
    modport decoder (output control, rs1, rs2, rd, imm, pc);

    // ALU and control only look
    modport consumer (input control, rs1, rs2, rd, imm, pc);

endinterface

//--- source/instruction_decoder.sv
module instruction_decoder (
    input  logic             i_clk,
    input  logic             i_reset,
    input  logic             i_instr_valid,
    input  rapid_pkg::word_t i_instruction,
    input  rapid_pkg::word_t i_pc,
    input  logic             i_accept,
    decode_if.decoder        dec
);
    import rapid_pkg::*;

    word_t      instr_q;
    word_t      pc_q;
    opcode_e    opcode;
    control_s   ctrl;
    word_t      imm;
    logic [6:0] block_flags;

    // Immediates in every format
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;

    ////////////////////////////////////////////////////////////////////////////
    // Capture on accepted strobe
    ////////////////////////////////////////////////////////////////////////////

    // Cleared word decodes as illegal with no block set
    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            instr_q <= '0;
        end
        else if (i_instr_valid && i_accept)
        begin
            instr_q <= i_instruction;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (i_instr_valid && i_accept)
        begin
            pc_q <= i_pc;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Decode of the held word
    ////////////////////////////////////////////////////////////////////////////

    assign opcode = opcode_e'(instr_q[6:0]);

    assign imm_i = {{20{instr_q[31]}}, instr_q[31:20]};
    assign imm_s = {{20{instr_q[31]}}, instr_q[31:25], instr_q[11:7]};
    assign imm_b = {{20{instr_q[31]}}, instr_q[7], instr_q[30:25], instr_q[11:8], 1'b0};
    assign imm_u = {instr_q[31:12], 12'b0};
    assign imm_j = {{12{instr_q[31]}}, instr_q[19:12], instr_q[20], instr_q[30:21], 1'b0};

    always_comb
    begin
        ctrl = '0;
        ctrl.fcs_opcode = instr_q[14:12];
        imm = '0;
        case (opcode)
            OP_UPPER:
            begin
                ctrl.load_upper = 1'b1;
                ctrl.uses_rd = 1'b1;
                imm = imm_u;
            end
            OP_UPPER_PC:
            begin
                ctrl.upper_pc = 1'b1;
                ctrl.uses_rd = 1'b1;
                imm = imm_u;
            end
            OP_JAL:
            begin
                ctrl.jump = 1'b1;
                ctrl.uses_rd = 1'b1;
                imm = imm_j;
            end
            OP_JALR:
            begin
                ctrl.jump_reg = 1'b1;
                ctrl.uses_rd = 1'b1;
                imm = imm_i;
            end
            OP_BRANCH:
            begin
                ctrl.cond_branch = 1'b1;
                imm = imm_b;
            end
            OP_ALU_IMM:
            begin
                // Bit 30 only matters for srai
                ctrl.alu_imm = 1'b1;
                ctrl.iop = instr_q[30];
                ctrl.uses_rd = 1'b1;
                imm = imm_i;
            end
            OP_ALU_REG:
            begin
                ctrl.alu_reg = 1'b1;
                ctrl.iop = instr_q[30];
                ctrl.uses_rd = 1'b1;
            end
            // Memory ops have no unit here
            OP_LOAD:
            begin
                ctrl.illegal = 1'b1;
                imm = imm_i;
            end
            OP_STORE:
            begin
                ctrl.illegal = 1'b1;
                imm = imm_s;
            end
            default:
            begin
                ctrl.illegal = 1'b1;
            end
        endcase
    end

    assign block_flags = {ctrl.load_upper, ctrl.upper_pc, ctrl.jump, ctrl.jump_reg,
                          ctrl.cond_branch, ctrl.alu_imm, ctrl.alu_reg};

    // Outputs to the bus
    assign dec.control = ctrl;
    assign dec.rs1     = instr_q[19:15];
    assign dec.rs2     = instr_q[24:20];
    assign dec.rd      = ctrl.uses_rd ? instr_q[11:7] : '0;
    assign dec.imm     = imm;
    assign dec.pc      = pc_q;

    // One block at most, and none for an illegal word
    assert property (@(posedge i_clk) disable iff (i_reset)
        $onehot0(block_flags) && !(ctrl.illegal && (|block_flags)));

endmodule

//--- source/register_file.sv
module register_file (
    input  logic                 i_clk,
    input  logic                 i_reset,
    input  logic                 i_we,
    input  rapid_pkg::reg_addr_t i_waddr,
    input  rapid_pkg::word_t     i_wdata,
    input  rapid_pkg::reg_addr_t i_raddr1,
    input  rapid_pkg::reg_addr_t i_raddr2,
    output rapid_pkg::word_t     o_rdata1,
    output rapid_pkg::word_t     o_rdata2
);
    import rapid_pkg::*;

    // Only x1 to x31 are stored
    word_t regs [1:31];

    // Single write port
    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            for (int i = 1; i < 32; i++)
            begin
                regs[i] <= '0;
            end
        end
        // Writes to x0 dropped
        else if (i_we && (i_waddr != '0))
        begin
            regs[i_waddr] <= i_wdata;
        end
    end

    // Combinational reads, x0 reads zero
    assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
    assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

    // Write address must be driven whenever a write happens
    assert property (@(posedge i_clk) disable iff (i_reset)
        i_we |-> !$isunknown(i_waddr));

endmodule

//--- source/alu.sv
module alu (
    decode_if.consumer       dec,
    input  rapid_pkg::word_t i_rs1_data,
    input  rapid_pkg::word_t i_rs2_data,
    output rapid_pkg::word_t o_result,
    output rapid_pkg::word_t o_jump_target,
    output logic             o_branch_taken
);
    import rapid_pkg::*;

    word_t      operand_b;
    word_t      alu_out;
    word_t      jalr_sum;
    logic [4:0] shamt;
    logic       do_sub;
    logic       cmp_true;

    ////////////////////////////////////////////////////////////////////////////
    // Integer ops
    ////////////////////////////////////////////////////////////////////////////

    // Immediate block uses imm, register block uses rs2
    assign operand_b = dec.control.alu_reg ? i_rs2_data : dec.imm;
    assign shamt     = operand_b[4:0];
    // Sub only exists in the register block
    assign do_sub    = dec.control.alu_reg && dec.control.iop;

    always_comb
    begin
        case (alu_op_e'(dec.control.fcs_opcode))
            ALU_ADD:  alu_out = do_sub ? (i_rs1_data - operand_b) : (i_rs1_data + operand_b);
            ALU_SLL:  alu_out = i_rs1_data << shamt;
            ALU_SLT:  alu_out = {31'b0, $signed(i_rs1_data) < $signed(operand_b)};
            ALU_SLTU: alu_out = {31'b0, i_rs1_data < operand_b};
            ALU_XOR:  alu_out = i_rs1_data ^ operand_b;
            // Arithmetic shift when iop set
            ALU_SRL:  alu_out = dec.control.iop ? word_t'($signed(i_rs1_data) >>> shamt)
                                                : (i_rs1_data >> shamt);
            ALU_OR:   alu_out = i_rs1_data | operand_b;
            ALU_AND:  alu_out = i_rs1_data & operand_b;
            default:  alu_out = '0;
        endcase
    end

    // Upper immediates and link value override the ALU
    always_comb
    begin
        if (dec.control.load_upper)
            o_result = dec.imm;
        else if (dec.control.upper_pc)
            o_result = dec.pc + dec.imm;
        else if (dec.control.jump || dec.control.jump_reg)
            o_result = dec.pc + 32'd4;
        else
            o_result = alu_out;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Branch compare and jump target
    ////////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        case (branch_op_e'(dec.control.fcs_opcode))
            BR_EQ:   cmp_true = (i_rs1_data == i_rs2_data);
            BR_NE:   cmp_true = (i_rs1_data != i_rs2_data);
            BR_LT:   cmp_true = ($signed(i_rs1_data) < $signed(i_rs2_data));
            BR_GE:   cmp_true = ($signed(i_rs1_data) >= $signed(i_rs2_data));
            BR_LTU:  cmp_true = (i_rs1_data < i_rs2_data);
            BR_GEU:  cmp_true = (i_rs1_data >= i_rs2_data);
            // funct3 010 and 011 never branch
            default: cmp_true = 1'b0;
        endcase
    end

    assign o_branch_taken = dec.control.cond_branch && cmp_true;

    // jalr clears bit 0, jal and branches are pc relative
    assign jalr_sum      = i_rs1_data + dec.imm;
    assign o_jump_target = dec.control.jump_reg ? {jalr_sum[31:1], 1'b0} : (dec.pc + dec.imm);

endmodule

//--- source/core_control.sv
module core_control #(
    parameter rapid_pkg::word_t RESET_PC = '0
) (
    input  logic                 i_clk,
    input  logic                 i_reset,
    input  logic                 i_instr_valid,
    decode_if.consumer           dec,
    input  rapid_pkg::word_t     i_result,
    input  rapid_pkg::word_t     i_jump_target,
    input  logic                 i_branch_taken,
    output logic                 o_accept,
    output logic                 o_ready,
    output logic                 o_done,
    output rapid_pkg::word_t     o_next_pc,
    output logic                 o_we,
    output rapid_pkg::reg_addr_t o_waddr,
    output rapid_pkg::word_t     o_wdata,
    output logic                 o_illegal
);
    import rapid_pkg::*;

    core_state_e state;
    core_state_e state_next;
    word_t       result_q;
    word_t       next_pc_q;
    logic        redirect;

    ////////////////////////////////////////////////////////////////////////////
    // Sequencer
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
            state <= WAIT;
        else
            state <= state_next;
    end

    // Strobes outside WAIT are simply ignored
    always_comb
    begin
        case (state)
            WAIT:      state_next = i_instr_valid ? DECODE : WAIT;
            DECODE:    state_next = EXECUTE;
            EXECUTE:   state_next = WRITEBACK;
            WRITEBACK: state_next = WAIT;
            default:   state_next = WAIT;
        endcase
    end

    // Taken control transfer
    assign redirect = dec.control.jump || dec.control.jump_reg || i_branch_taken;

    // Pc holds its value between instructions
    always_ff @(posedge i_clk)
    begin
        if (i_reset)
            next_pc_q <= RESET_PC;
        else if (state == EXECUTE)
            next_pc_q <= redirect ? i_jump_target : (dec.pc + 32'd4);
    end

    always_ff @(posedge i_clk)
    begin
        if (state == EXECUTE)
            result_q <= i_result;
    end

    // Outputs
    assign o_accept  = (state == WAIT);
    assign o_ready   = (state == WAIT);
    assign o_done    = (state == WRITEBACK);
    assign o_next_pc = next_pc_q;
    assign o_we      = o_done && dec.control.uses_rd && !dec.control.illegal;
    assign o_waddr   = dec.rd;
    assign o_wdata   = result_q;
    assign o_illegal = o_done && dec.control.illegal;

    // Done only for a strobe accepted three cycles before
    assert property (@(posedge i_clk) disable iff (i_reset)
        o_done |-> $past(o_accept && i_instr_valid, 3));

    // Accepted strobe finishes three cycles later
    assert property (@(posedge i_clk) disable iff (i_reset)
        (o_accept && i_instr_valid) |-> ##3 o_done);

endmodule

//--- source/rapid_core.sv
module rapid_core #(
    parameter rapid_pkg::word_t RESET_PC = '0
) (
    input  logic                 i_clk,
    input  logic                 i_reset,
    input  logic                 i_instr_valid,
    input  rapid_pkg::word_t     i_instruction,
    input  rapid_pkg::word_t     i_pc,
    output logic                 o_ready,
    output logic                 o_done,
    output rapid_pkg::word_t     o_next_pc,
    output logic                 o_wb_valid,
    output rapid_pkg::reg_addr_t o_wb_rd,
    output rapid_pkg::word_t     o_wb_data,
    output logic                 o_illegal
);
    import rapid_pkg::*;

    // Decoded instruction shared by ALU and control
    decode_if dec_bus ();

    logic      accept;
    word_t     rs1_data;
    word_t     rs2_data;
    word_t     alu_result;
    word_t     jump_target;
    logic      branch_taken;
    logic      wb_we;
    reg_addr_t wb_addr;
    word_t     wb_data;

    ////////////////////////////////////////////////////////////////////////////
    // Datapath
    ////////////////////////////////////////////////////////////////////////////

    instruction_decoder u_decoder (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_instr_valid (i_instr_valid),
        .i_instruction (i_instruction),
        .i_pc          (i_pc),
        .i_accept      (accept),
        .dec           (dec_bus.decoder)
    );

    // Read ports follow the decoded fields
    register_file u_regfile (
        .i_clk    (i_clk),
        .i_reset  (i_reset),
        .i_we     (wb_we),
        .i_waddr  (wb_addr),
        .i_wdata  (wb_data),
        .i_raddr1 (dec_bus.rs1),
        .i_raddr2 (dec_bus.rs2),
        .o_rdata1 (rs1_data),
        .o_rdata2 (rs2_data)
    );

    alu u_alu (
        .dec            (dec_bus.consumer),
        .i_rs1_data     (rs1_data),
        .i_rs2_data     (rs2_data),
        .o_result       (alu_result),
        .o_jump_target  (jump_target),
        .o_branch_taken (branch_taken)
    );

    core_control #(
        .RESET_PC (RESET_PC)
    ) u_control (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_instr_valid  (i_instr_valid),
        .dec            (dec_bus.consumer),
        .i_result       (alu_result),
        .i_jump_target  (jump_target),
        .i_branch_taken (branch_taken),
        .o_accept       (accept),
        .o_ready        (o_ready),
        .o_done         (o_done),
        .o_next_pc      (o_next_pc),
        .o_we           (wb_we),
        .o_waddr        (wb_addr),
        .o_wdata        (wb_data),
        .o_illegal      (o_illegal)
    );

    // Write-back is visible in the same cycle as the register write
    assign o_wb_valid = wb_we;
    assign o_wb_rd    = wb_addr;
    assign o_wb_data  = wb_data;

endmodule

//--- tests/rapid_core_tb.sv
module rapid_core_tb;
    import rapid_pkg::*;

    localparam word_t RESET_PC       = 32'h0000_0400;
    localparam int    TIMEOUT_CYCLES = 20;
    localparam int    RANDOM_COUNT   = 300;
    // Small register pool so results feed later instructions
    localparam reg_addr_t REG_POOL [8] = '{5'd0, 5'd1, 5'd2, 5'd5, 5'd7, 5'd12, 5'd20, 5'd31};

    // Expected response of one instruction
    typedef struct packed {
        logic      wb_valid;
        reg_addr_t rd;
        word_t     data;
        word_t     next_pc;
        logic      illegal;
    } expect_s;

    typedef word_t reg_array_t [32];

    logic        i_clk;
    logic        i_reset;
    logic        i_instr_valid;
    word_t       i_instruction;
    word_t       i_pc;
    logic        o_ready;
    logic        o_done;
    word_t       o_next_pc;
    logic        o_wb_valid;
    reg_addr_t   o_wb_rd;
    word_t       o_wb_data;
    logic        o_illegal;

    // Model state and bookkeeping
    reg_array_t  model_regs;
    word_t       model_pc;
    logic [31:0] lfsr_state;
    expect_s     expected_q [$];
    int          error_count;
    int          timeout_count;
    int          instr_count;
    logic        aborted;

    rapid_core #(
        .RESET_PC (RESET_PC)
    ) DUT (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_instr_valid (i_instr_valid),
        .i_instruction (i_instruction),
        .i_pc          (i_pc),
        .o_ready       (o_ready),
        .o_done        (o_done),
        .o_next_pc     (o_next_pc),
        .o_wb_valid    (o_wb_valid),
        .o_wb_rd       (o_wb_rd),
        .o_wb_data     (o_wb_data),
        .o_illegal     (o_illegal)
    );

    // Period of 4
    always
    begin
        #2 i_clk = ~i_clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus generation
    ////////////////////////////////////////////////////////////////////////////

    // Galois form, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // One LFSR step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic reg_addr_t pick_reg();
        return REG_POOL[3'(take_bits(3))];
    endfunction

    // Branch with a fixed offset of +16
    function automatic word_t branch_word(input logic [2:0] f3, input reg_addr_t rs1,
                                          input reg_addr_t rs2);
        return {7'b0, rs2, rs1, f3, 5'b10000, 7'b1100011};
    endfunction

    function automatic word_t random_instr();
        logic [3:0]  family;
        logic [2:0]  f3;
        reg_addr_t   rd;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        logic [11:0] imm12;
        logic [19:0] upper;
        logic        alt;
        logic [6:0]  op;
        word_t       instr;
        family = 4'(take_bits(4));
        f3     = 3'(take_bits(3));
        rd     = pick_reg();
        rs1    = pick_reg();
        rs2    = pick_reg();
        imm12  = 12'(take_bits(12));
        upper  = 20'(take_bits(20));
        alt    = 1'(take_bits(1));
        // Register ops get the heaviest share
        if (family < 4'd5)
        begin
            alt   = alt && (f3 == 3'b000 || f3 == 3'b101);
            instr = {1'b0, alt, 5'b0, rs2, rs1, f3, rd, 7'b0110011};
        end
        else if (family < 4'd9)
        begin
            // Shifts hold shamt and the arithmetic bit in the immediate
            if (f3 == 3'b001 || f3 == 3'b101)
                imm12 = {1'b0, alt && (f3 == 3'b101), 5'b0, imm12[4:0]};
            instr = {imm12, rs1, f3, rd, 7'b0010011};
        end
        else if (family == 4'd9)
            instr = {upper, rd, 7'b0110111};
        else if (family == 4'd10)
            instr = {upper, rd, 7'b0010111};
        else if (family == 4'd11)
        begin
            // Offset bit 1 cleared, keeps targets word aligned
            upper[9] = 1'b0;
            instr = {upper, rd, 7'b1101111};
        end
        else if (family == 4'd12)
            instr = {imm12, rs1, 3'b000, rd, 7'b1100111};
        else if (family < 4'd15)
        begin
            // Fold 010 and 011 onto eq and ne
            if (!f3[2])
                f3[1] = 1'b0;
            instr = {imm12[11:5], rs2, rs1, f3, imm12[4:2], 1'b0, imm12[0], 7'b1100011};
        end
        else
        begin
            case (2'(take_bits(2)))
                2'd0:    op = 7'b0000011;
                2'd1:    op = 7'b0100011;
                2'd2:    op = 7'b0001011;
                default: op = 7'b1110011;
            endcase
            instr = {imm12, rs1, f3, rd, op};
        end
        return instr;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////

    // Signed compare by flipping the sign bits
    function automatic logic signed_less(input word_t a, input word_t b);
        return (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000);
    endfunction

    function automatic word_t alu_model(input logic [2:0] f3, input word_t a, input word_t b,
                                        input logic alt);
        logic [4:0] sh;
        sh = b[4:0];
        case (f3)
            3'b000:  return alt ? (a - b) : (a + b);
            3'b001:  return a << sh;
            3'b010:  return {31'b0, signed_less(a, b)};
            3'b011:  return {31'b0, a < b};
            3'b100:  return a ^ b;
            // Arithmetic shift fills with the sign
            3'b101:  return (alt && a[31]) ? ~(~a >> sh) : (a >> sh);
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic expect_s reference_result(input word_t instr, input word_t pc,
                                                 input reg_array_t regs);
        expect_s    r;
        word_t      a;
        word_t      b;
        word_t      imm_i;
        word_t      imm_b;
        word_t      imm_u;
        word_t      imm_j;
        logic [2:0] f3;
        logic       taken;
        f3    = instr[14:12];
        a     = regs[instr[19:15]];
        b     = regs[instr[24:20]];
        imm_i = {{20{instr[31]}}, instr[31:20]};
        imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
        imm_u = {instr[31:12], 12'h000};
        imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
        r          = '0;
        r.next_pc  = pc + 32'd4;
        r.wb_valid = 1'b1;
        case (instr[6:0])
            7'b0110111: r.data = imm_u;
            7'b0010111: r.data = pc + imm_u;
            7'b1101111:
            begin
                r.data    = pc + 32'd4;
                r.next_pc = pc + imm_j;
            end
            7'b1100111:
            begin
                r.data    = pc + 32'd4;
                r.next_pc = (a + imm_i) & ~32'd1;
            end
            7'b1100011:
            begin
                r.wb_valid = 1'b0;
                case (f3)
                    3'b000:  taken = (a == b);
                    3'b001:  taken = (a != b);
                    3'b100:  taken = signed_less(a, b);
                    3'b101:  taken = !signed_less(a, b);
                    3'b110:  taken = (a < b);
                    3'b111:  taken = !(a < b);
                    default: taken = 1'b0;
                endcase
                if (taken)
                    r.next_pc = pc + imm_b;
            end
            // Sub only in the register block
            7'b0010011: r.data = alu_model(f3, a, imm_i, instr[30] && (f3 == 3'b101));
            7'b0110011: r.data = alu_model(f3, a, b, instr[30]);
            default:
            begin
                r.wb_valid = 1'b0;
                r.illegal  = 1'b1;
            end
        endcase
        // rd reads zero for families that write nothing
        if (r.wb_valid)
            r.rd = instr[11:7];
        return r;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Reporting
    ////////////////////////////////////////////////////////////////////////////

    task automatic report_mismatch(input string what, input word_t got, input word_t want);
        error_count++;
        $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, want);
    endtask

    task automatic report_failure(input string what);
        error_count++;
        $display("Failure at time %0t: %s", $time, what);
    endtask

    task automatic report_timeout(input string what);
        timeout_count++;
        aborted = 1'b1;
        $display("Gave up after %0d cycles waiting for %s at time %0t",
                 TIMEOUT_CYCLES, what, $time);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Driver
    ////////////////////////////////////////////////////////////////////////////

    task automatic idle(input int n);
        repeat (n) @(negedge i_clk);
    endtask

    // Offer one instruction, optionally strobing again while busy
    task automatic run_instr(input word_t instr, input logic extra_strobe);
        expect_s want;
        int      cycles;
        if (aborted)
            return;
        cycles = 0;
        while (!o_ready && cycles < TIMEOUT_CYCLES)
        begin
            @(negedge i_clk);
            cycles++;
        end
        if (!o_ready)
        begin
            report_timeout("o_ready");
            return;
        end
        want = reference_result(instr, model_pc, model_regs);
        expected_q.push_back(want);
        // Model runs ahead, one instruction in flight
        if (want.wb_valid && want.rd != 5'd0)
            model_regs[want.rd] = want.data;
        i_instr_valid = 1'b1;
        i_instruction = instr;
        i_pc          = model_pc;
        model_pc      = want.next_pc;
        instr_count++;
        @(negedge i_clk);
        cycles        = 1;
        i_instr_valid = extra_strobe;
        if (extra_strobe)
        begin
            // addi x1, x0, 1 which the busy core must drop
            i_instruction = 32'h0010_0093;
            assert (!o_ready) else report_failure("o_ready high while decoding");
        end
        while (!o_done && cycles < TIMEOUT_CYCLES)
        begin
            @(negedge i_clk);
            i_instr_valid = 1'b0;
            cycles++;
        end
        if (!o_done)
        begin
            report_timeout("o_done");
            return;
        end
        assert (cycles == 3) else report_mismatch("o_done latency", 32'(cycles), 32'd3);
        @(negedge i_clk);
        assert (o_ready) else report_failure("o_ready did not return after o_done");
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Output compare, mid cycle
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge i_clk)
    begin : compare_outputs
        expect_s want;
        if (i_reset == 1'b0)
        begin
            if (o_done)
            begin
                assert (expected_q.size() != 0)
                    else report_failure("o_done pulsed with no instruction in flight");
                if (expected_q.size() != 0)
                begin
                    want = expected_q.pop_front();
                    assert (o_wb_valid == want.wb_valid)
                        else report_mismatch("o_wb_valid", 32'(o_wb_valid), 32'(want.wb_valid));
                    assert (o_wb_rd == want.rd)
                        else report_mismatch("o_wb_rd", 32'(o_wb_rd), 32'(want.rd));
                    // Data matters only on a write
                    assert (!want.wb_valid || o_wb_data == want.data)
                        else report_mismatch("o_wb_data", o_wb_data, want.data);
                    assert (o_next_pc == want.next_pc)
                        else report_mismatch("o_next_pc", o_next_pc, want.next_pc);
                    assert (o_illegal == want.illegal)
                        else report_mismatch("o_illegal", 32'(o_illegal), 32'(want.illegal));
                end
            end
            else
            begin
                assert (!o_wb_valid && !o_illegal)
                    else report_failure("write-back or illegal flag raised without o_done");
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial
    begin
        i_clk         = 1'b0;
        i_reset       = 1'b1;
        i_instr_valid = 1'b0;
        i_instruction = '0;
        i_pc          = '0;
        error_count   = 0;
        timeout_count = 0;
        instr_count   = 0;
        aborted       = 1'b0;
        lfsr_state    = 32'd69795;
        model_pc      = RESET_PC;
        for (int r = 0; r < 32; r++)
            model_regs[r] = '0;
        repeat (2) @(posedge i_clk);
        @(negedge i_clk);
        i_reset = 1'b0;

        // Idle outputs straight out of reset
        assert (o_ready && !o_done && !o_wb_valid && !o_illegal)
            else report_failure("control outputs wrong after reset");
        assert (o_next_pc == RESET_PC)
            else report_mismatch("o_next_pc after reset", o_next_pc, RESET_PC);

        // addi x0, x0, 123 then add x1, x0, x0 reads it back
        run_instr(32'h07b0_0013, 1'b0);
        run_instr(32'h0000_00b3, 1'b0);
        // lw, sw and a custom opcode
        run_instr(32'h0000_a283, 1'b0);
        run_instr(32'h0020_a023, 1'b0);
        run_instr(32'h0000_000b, 1'b0);
        // Second strobe during decode
        run_instr(32'h0050_0113, 1'b1);
        idle(6);

        // x1 = 5, x2 = -3 then every branch on three operand pairs
        run_instr(32'h0050_0093, 1'b0);
        run_instr(32'hffd0_0113, 1'b0);
        for (int f = 0; f < 8; f++)
        begin
            if (f != 2 && f != 3)
            begin
                run_instr(branch_word(3'(f), 5'd1, 5'd1), 1'b0);
                run_instr(branch_word(3'(f), 5'd2, 5'd1), 1'b0);
                run_instr(branch_word(3'(f), 5'd1, 5'd2), 1'b0);
            end
        end

        for (int n = 0; n < RANDOM_COUNT; n++)
            run_instr(random_instr(), 1'b0);
        idle(4);

        $display("Summary: %0d instructions, %0d errors, %0d timeouts",
                 instr_count, error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0 && expected_q.size() == 0)
        begin
            $display("Regression passed");
        end
        else
        begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- rapid_core.f
source/rapid_pkg.sv
source/decode_if.sv
source/instruction_decoder.sv
source/register_file.sv
source/alu.sv
source/core_control.sv
source/rapid_core.sv
tests/rapid_core_tb.sv

//--- Makefile
# Verilator build and run for rapid_core

VERILATOR ?= verilator
TOP       ?= rapid_core_tb
FILELIST  ?= rapid_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

# Sources taken from the file list so edits trigger a rebuild
SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Result comes from the log, not the exit status
run: $(SIM_BIN)
	-$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Regression failed" $(LOG); then \
		echo "Simulation reported failure, see $(LOG)"; \
		exit 1; \
	fi
	@grep -q "Regression passed" $(LOG) || (echo "No result found in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
